/* hw/conv_data_pkg.sv */
// Convolution datapath package with sample, weight, accumulator and position types
package conv_data_pkg;

    // --------------------
    // Widths
    // --------------------
    parameter int DATA_W = 16;  // Samples and weights
    parameter int ACC_W  = 40;  // Room for 8 full products plus bias

    // --------------------
    // Value types
    // --------------------
    typedef logic signed [DATA_W-1:0] sample_t;  // Input sample
    typedef logic signed [DATA_W-1:0] weight_t;  // Kernel tap
    typedef logic signed [ACC_W-1:0]  acc_t;     // Running sum and result

    // Sample position, negative in the left pad and past length in the right pad
    typedef logic signed [8:0] pos_t;

    // One write into either buffer
    typedef struct packed {
        logic       en;    // Write strobe
        logic [7:0] addr;  // Sample index or tap number
        sample_t    data;  // Weights share the sample width
    } buf_wr_t;

endpackage

/* hw/conv_ctrl_pkg.sv */
// Convolution control package with the job configuration and sequencer states
package conv_ctrl_pkg;

    // --------------------
    // Job configuration
    // --------------------
    typedef struct packed {
        logic [6:0]          length;       // 1..64 samples
        logic [3:0]          kernel_size;  // 1..8 taps
        logic [1:0]          stride;       // 1..3
        logic [1:0]          padding;      // 0..3 zeros on each side
        conv_data_pkg::acc_t bias;         // Seed of every output
    } conv_cfg_t;

    // --------------------
    // Sequencer states
    // --------------------
    typedef enum logic [2:0] {
        IDLE,   // Waiting for start, buffers writable
        CLEAR,  // Load bias into the accumulator
        ACCUM,  // One tap read per cycle
        DRAIN,  // Last read datum lands in the accumulator
        HOLD    // Result offered until taken
    } ctrl_state_t;

endpackage

/* hw/ifmap_buffer.sv */
// Input sample buffer with a write port and a zero-padded registered read
`timescale 1ns/1ps

module ifmap_buffer #(
    parameter int MAX_LEN = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_data_pkg::buf_wr_t wr,
    input  logic                   wr_allow,   // Low while a job runs
    input  logic [6:0]             length,     // From the latched config
    input  conv_data_pkg::pos_t    rd_pos,
    output conv_data_pkg::sample_t rd_sample
);
    import conv_data_pkg::*;

    localparam int AW = $clog2(MAX_LEN);

    sample_t mem [MAX_LEN];
    logic    wr_ok;
    logic    in_range;

    // --------------------
    // Write side
    // --------------------
    // Addresses past the depth would alias, so they are dropped
    assign wr_ok = wr.en && wr_allow && (wr.addr < 8'(MAX_LEN));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr.addr[AW-1:0]] <= wr.data;
        end
    end

    // --------------------
    // Read side
    // --------------------
    // Anything left of 0 or at/after length is padding
    assign in_range = (rd_pos >= 0) && (rd_pos < pos_t'(length));

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_sample <= '0;
        end else if (in_range) begin
            rd_sample <= mem[rd_pos[AW-1:0]];  // Stored sample
        end else begin
            rd_sample <= '0;                   // Pad value
        end
    end

endmodule

/* hw/weight_buffer.sv */
// Kernel weight buffer with a write port and a registered tap read
`timescale 1ns/1ps

module weight_buffer #(
    parameter int MAX_KERNEL = 8
) (
    input  logic                   clk,
    input  conv_data_pkg::buf_wr_t wr,
    input  logic                   wr_allow,  // Low while a job runs
    input  logic [2:0]             rd_tap,
    output conv_data_pkg::weight_t rd_weight
);
    import conv_data_pkg::*;

    localparam int TW = $clog2(MAX_KERNEL);

    weight_t mem [MAX_KERNEL];

    // Only the low address bits pick the tap
    always_ff @(posedge clk) begin
        if (wr.en && wr_allow) begin
            mem[wr.addr[TW-1:0]] <= wr.data;
        end
    end

    // One cycle read latency, same as the sample side
    always_ff @(posedge clk) begin
        rd_weight <= mem[rd_tap];
    end

endmodule

/* hw/mac_unit.sv */
// Multiply-accumulate stage that starts each window from the bias
`timescale 1ns/1ps

module mac_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   acc_clear,  // Start of a window
    input  logic                   acc_en,     // Buffer data valid this cycle
    input  conv_data_pkg::acc_t    bias,
    input  conv_data_pkg::sample_t sample,
    input  conv_data_pkg::weight_t weight,
    output conv_data_pkg::acc_t    acc
);
    import conv_data_pkg::*;

    logic signed [2*DATA_W-1:0] product;

    // Full-width signed product, no rounding
    assign product = sample * weight;

    // --------------------
    // Accumulator
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= bias;                    // Seed for the new window
        end else if (acc_en) begin
            acc <= acc + acc_t'(product);   // Sign-extended add
        end
        // Otherwise hold, keeps the offered result steady
    end

endmodule

/* hw/conv_ctrl.sv */
// Convolution sequencer that steps windows and taps and drives the result handshake
`timescale 1ns/1ps

module conv_ctrl #(
    parameter int MAX_LEN    = 64,
    parameter int MAX_KERNEL = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  conv_ctrl_pkg::conv_cfg_t cfg_in,
    output conv_ctrl_pkg::conv_cfg_t cfg,        // Latched at start
    output conv_data_pkg::pos_t      rd_pos,
    output logic [2:0]               rd_tap,
    output logic                     acc_clear,
    output logic                     acc_en,
    output logic                     res_valid,
    output logic                     res_last,
    input  logic                     res_ready,
    output logic                     busy,
    output logic                     done
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    // Window indices and bases stay below length plus the kernel reach
    localparam int CW = $clog2(MAX_LEN + MAX_KERNEL);

    typedef logic [CW-1:0] win_t;

    ctrl_state_t state;
    win_t        base;      // First position of the window, before padding
    win_t        out_idx;   // Current window number
    win_t        out_last;  // Number of the final window
    logic [2:0]  tap;
    logic [7:0]  span;      // length + 2*padding - kernel_size
    logic        last_tap;
    logic        last_win;

    // --------------------
    // Job setup
    // --------------------
    assign span = 8'(cfg_in.length) + 8'({cfg_in.padding, 1'b0}) - 8'(cfg_in.kernel_size);

    // Config and window count taken once per job
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cfg      <= cfg_in;
            out_last <= win_t'(span / 8'(cfg_in.stride));  // Floor division
        end
    end

    assign last_tap = ({1'b0, tap} == cfg.kernel_size - 4'd1);
    assign last_win = (out_idx == out_last);

    // --------------------
    // Sequencer
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= IDLE;
            tap     <= '0;
            base    <= '0;
            out_idx <= '0;
            acc_en  <= 1'b0;
            done    <= 1'b0;
        end else begin
            acc_en <= (state == ACCUM);  // Read strobe delayed by buffer latency
            done   <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        base    <= '0;
                        out_idx <= '0;
                        state   <= CLEAR;
                    end
                end
                CLEAR: begin
                    tap   <= '0;
                    state <= ACCUM;
                end
                ACCUM: begin
                    if (last_tap) begin
                        state <= DRAIN;
                    end else begin
                        tap <= tap + 3'd1;
                    end
                end
                DRAIN: state <= HOLD;  // Final product goes in here
                HOLD: begin
                    if (res_ready) begin
                        if (last_win) begin
                            state <= IDLE;
                            done  <= 1'b1;  // Same cycle busy drops
                        end else begin
                            base    <= base + win_t'(cfg.stride);
                            out_idx <= out_idx + win_t'(1);
                            state   <= CLEAR;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // --------------------
    // Outputs
    // --------------------
    // Position may go negative in the left pad
    assign rd_pos    = pos_t'(base) + pos_t'(tap) - pos_t'(cfg.padding);
    assign rd_tap    = tap;
    assign acc_clear = (state == CLEAR);
    assign res_valid = (state == HOLD);
    assign res_last  = res_valid && last_win;
    assign busy      = (state != IDLE);

endmodule

/* hw/conv1d_top.sv */
// Single-lane 1D convolution engine top with buffers, MAC and sequencer
`timescale 1ns/1ps

module conv1d_top #(
    parameter int MAX_LEN    = 64,
    parameter int MAX_KERNEL = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  conv_data_pkg::buf_wr_t   sample_wr,
    input  conv_data_pkg::buf_wr_t   weight_wr,
    input  logic                     start,
    input  conv_ctrl_pkg::conv_cfg_t cfg,
    output logic                     res_valid,
    input  logic                     res_ready,
    output conv_data_pkg::acc_t      res_data,
    output logic                     res_last,
    output logic                     busy,
    output logic                     done
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    conv_cfg_t cfg_latched;  // Config of the running job
    pos_t      rd_pos;
    logic [2:0] rd_tap;
    logic      acc_clear;
    logic      acc_en;
    logic      wr_allow;
    sample_t   rd_sample;
    weight_t   rd_weight;

    assign wr_allow = ~busy;  // Buffers frozen during a job

    // --------------------
    // Sequencer
    // --------------------
    conv_ctrl #(
        .MAX_LEN    (MAX_LEN),
        .MAX_KERNEL (MAX_KERNEL)
    ) conv_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg_in    (cfg),
        .cfg       (cfg_latched),
        .rd_pos    (rd_pos),
        .rd_tap    (rd_tap),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .res_valid (res_valid),
        .res_last  (res_last),
        .res_ready (res_ready),
        .busy      (busy),
        .done      (done)
    );

    // --------------------
    // Datapath
    // --------------------
    ifmap_buffer #(
        .MAX_LEN (MAX_LEN)
    ) ifmap_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .wr        (sample_wr),
        .wr_allow  (wr_allow),
        .length    (cfg_latched.length),
        .rd_pos    (rd_pos),
        .rd_sample (rd_sample)
    );

    weight_buffer #(
        .MAX_KERNEL (MAX_KERNEL)
    ) weight_buffer_inst (
        .clk       (clk),
        .wr        (weight_wr),
        .wr_allow  (wr_allow),
        .rd_tap    (rd_tap),
        .rd_weight (rd_weight)
    );

    mac_unit mac_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .bias      (cfg_latched.bias),
        .sample    (rd_sample),
        .weight    (rd_weight),
        .acc       (res_data)   // Held while stalled
    );

endmodule

/* bench/conv1d_props.sv */
// Handshake and control properties of the convolution engine top
`timescale 1ns/1ps

module conv1d_props (
    input logic                clk,
    input logic                rst,
    input logic                res_valid,
    input logic                res_ready,
    input conv_data_pkg::acc_t res_data,
    input logic                res_last,
    input logic                busy,
    input logic                done
);
    int fail_count = 0;  // Read by the testbench top

    // --------------------
    // Result stream
    // --------------------
    stall_hold: assert property (@(posedge clk) disable iff (!rst)
        res_valid && !res_ready |=> $stable(res_data) && $stable(res_last))
        else begin
            fail_count++;
            $error("result changed while stalled");
        end

    // A result needs a job that already ran for at least a cycle
    valid_in_job: assert property (@(posedge clk) disable iff (!rst)
        res_valid |-> busy && $past(busy))
        else begin
            fail_count++;
            $error("res_valid high while idle");
        end

    // --------------------
    // Job control
    // --------------------
    done_single: assert property (@(posedge clk) disable iff (!rst)
        done |-> !busy && $past(busy) ##1 !done)
        else begin
            fail_count++;
            $error("done not a single pulse at busy fall");
        end

    busy_fall: assert property (@(posedge clk) disable iff (!rst) $fell(busy) |-> done)
        else begin
            fail_count++;
            $error("busy fell without done");
        end

    // Outputs quiet right after a reset cycle
    reset_quiet: assert property (@(posedge clk) !rst |=> !busy && !done && !res_valid)
        else begin
            fail_count++;
            $error("outputs active after reset");
        end

endmodule

bind conv1d_top conv1d_props conv1d_props_inst (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_last  (res_last),
    .busy      (busy),
    .done      (done)
);

/* bench/conv1d_checker.sv */
// Convolution result checker with a shadow of both buffers and a window reference model
`timescale 1ns/1ps

module conv1d_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  conv_data_pkg::buf_wr_t   sample_wr,
    input  conv_data_pkg::buf_wr_t   weight_wr,
    input  logic                     start,
    input  conv_ctrl_pkg::conv_cfg_t cfg,
    input  logic                     busy,
    input  logic                     res_valid,
    input  logic                     res_ready,
    input  conv_data_pkg::acc_t      res_data,
    input  logic                     res_last,
    input  logic                     done,
    input  logic [95:0]              case_name,
    input  int                       exp_count,
    output int                       errors
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    sample_t     samp [64];        // Shadow sample buffer
    weight_t     wts [8];          // Shadow weights
    longint      expect_q [$];     // Pending results of the job
    int          err_count  = 0;
    int          n_expected = -1;  // -1 when no job runs
    int          n_seen     = 0;
    longint      exp_val;
    logic [95:0] job_name;         // Case that owns the running job
    int          job_count  = 0;   // Its window count from the table

    assign errors = err_count;

    // Zero outside 0..length-1, window base advances by stride
    function automatic void predict(input conv_cfg_t c);
        longint sum;
        int     n;
        int     pos;
        expect_q.delete();
        n = (int'(c.length) + 2 * int'(c.padding) - int'(c.kernel_size)) / int'(c.stride) + 1;
        for (int o = 0; o < n; o++) begin
            sum = longint'(c.bias);
            for (int k = 0; k < int'(c.kernel_size); k++) begin
                pos = o * int'(c.stride) + k - int'(c.padding);
                if (pos >= 0 && pos < int'(c.length)) begin
                    sum += longint'(samp[pos[5:0]]) * longint'(wts[k[2:0]]);
                end
            end
            expect_q.push_back(sum);
        end
        n_expected = n;
        n_seen     = 0;
    endfunction

    // --------------------
    // Snoop and compare
    // --------------------
    always @(posedge clk) begin
        if (rst) begin
            if (sample_wr.en && !busy && sample_wr.addr < 8'd64) begin
                samp[sample_wr.addr[5:0]] = sample_wr.data;
            end
            if (weight_wr.en && !busy) begin
                wts[weight_wr.addr[2:0]] = weight_wr.data;  // Low bits only
            end
            if (start && !busy) begin
                predict(cfg);
                job_name  = case_name;
                job_count = exp_count;
            end
            if (res_valid && res_ready) begin
                if (expect_q.size() == 0) begin
                    err_count++;
                    $display("unexpected extra result in case %0s", case_name);
                end else begin
                    exp_val = expect_q.pop_front();
                    if (longint'(res_data) != exp_val) begin
                        err_count++;
                        $display("mismatch %0s: expected %0d, actual %0d", case_name, exp_val,
                                 longint'(res_data));
                    end
                    if (res_last != (expect_q.size() == 0)) begin
                        err_count++;
                        $display("res_last wrong in case %0s at result %0d", case_name, n_seen);
                    end
                    n_seen++;
                end
            end
            if (done) begin
                if (n_expected < 0) begin
                    err_count++;
                    $display("done pulse without a running job in case %0s", case_name);
                end else if (n_seen != job_count) begin
                    err_count++;
                    $display("mismatch %0s count: expected %0d, actual %0d", job_name,
                             job_count, n_seen);
                end
                n_expected = -1;
            end
        end
    end

endmodule

/* bench/conv1d_tb.sv */
// Convolution engine testbench with case table, LFSR stimulus and closing report
`timescale 1ns/1ps

module conv1d_tb;
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int          NCASE   = 9;
    localparam int          TIMEOUT = 2000;       // Cycles per wait
    localparam logic [31:0] SEED    = 32'd87291;

    typedef struct packed {
        logic [95:0] name;       // Up to 12 characters
        int          length;
        int          kernel;
        int          stride;
        int          padding;
        longint      bias;
        int          ready_pct;  // Chance of res_ready per cycle
        int          n_out;      // Results the job must produce
    } case_t;

    // --------------------
    // Case table
    // --------------------
    // Last column is the window count worked out by hand
    localparam case_t CASES [NCASE] = '{
        '{"basic",    16, 3, 1, 0, 5,       100, 14},
        '{"pad1",     12, 3, 1, 1, 0,       100, 12},
        '{"pad3_k8",  10, 8, 1, 3, 100,     100, 9},
        '{"stride2",  20, 4, 2, 1, -7,      100, 10},
        '{"stride3",  64, 5, 3, 2, 1000,    100, 22},
        '{"stall",    16, 3, 1, 0, 5,       40,  14},
        '{"negbias",  33, 8, 2, 3, -123456, 60,  16},
        '{"tiny",     1,  1, 1, 0, -1,      70,  1},
        '{"one_win",  8,  8, 3, 0, -50000,  50,  1}
    };

    logic        clk = 1'b0;
    logic        rst;
    buf_wr_t     sample_wr;
    buf_wr_t     weight_wr;
    logic        start;
    conv_cfg_t   cfg;
    logic        res_valid;
    logic        res_ready;
    acc_t        res_data;
    logic        res_last;
    logic        busy;
    logic        done;
    logic [95:0] case_name;
    int          exp_count;
    logic [31:0] lfsr = SEED;
    int          chk_errors;
    int          timeouts = 0;
    int          total;

    always #10 clk = ~clk;  // 20 ns period

    conv1d_top #(
        .MAX_LEN    (64),
        .MAX_KERNEL (8)
    ) conv1d_top_inst (
        .clk       (clk),
        .rst       (rst),
        .sample_wr (sample_wr),
        .weight_wr (weight_wr),
        .start     (start),
        .cfg       (cfg),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last),
        .busy      (busy),
        .done      (done)
    );

    conv1d_checker result_check (
        .clk       (clk),
        .rst       (rst),
        .sample_wr (sample_wr),
        .weight_wr (weight_wr),
        .start     (start),
        .cfg       (cfg),
        .busy      (busy),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last),
        .done      (done),
        .case_name (case_name),
        .exp_count (exp_count),
        .errors    (chk_errors)
    );

    // --------------------
    // Random source
    // --------------------
    // 32-bit Fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            timeouts++;
            $display("timeout: engine still busy before case %0s", case_name);
        end
    endtask

    // Random ready until the done pulse shows up
    task automatic wait_done(input int pct);
        logic [31:0] v;
        int          cycles;
        logic        seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            draw_bits(7, v);
            res_ready = (int'(v[6:0]) % 100) < pct;
            seen      = done;
            cycles++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no done pulse in case %0s", case_name);
        end
    endtask

    task automatic run_case(input case_t c);
        logic [31:0] v;
        int          n;
        case_name = c.name;
        exp_count = c.n_out;
        wait_idle();
        n = (c.length > c.kernel) ? c.length : c.kernel;
        for (int i = 0; i < n; i++) begin  // Samples and taps side by side
            @(negedge clk);
            draw_bits(16, v);
            sample_wr = '{en: (i < c.length), addr: 8'(i), data: sample_t'(v[15:0])};
            draw_bits(16, v);
            weight_wr = '{en: (i < c.kernel), addr: 8'(i), data: sample_t'(v[15:0])};
        end
        @(negedge clk);
        sample_wr = '0;
        weight_wr = '0;
        start     = 1'b1;
        cfg       = '{length: 7'(c.length), kernel_size: 4'(c.kernel), stride: 2'(c.stride),
                      padding: 2'(c.padding), bias: acc_t'(c.bias)};
        @(negedge clk);
        // Stray start and writes while busy, all to be dropped
        cfg.bias   = '1;
        cfg.stride = 2'd1;
        sample_wr  = '{en: 1'b1, addr: 8'd0, data: 16'sh7fff};
        weight_wr  = '{en: 1'b1, addr: 8'd0, data: 16'sh7fff};
        @(negedge clk);
        start     = 1'b0;
        sample_wr = '0;
        weight_wr = '0;
        wait_done(c.ready_pct);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst       = 1'b0;
        sample_wr = '0;
        weight_wr = '0;
        start     = 1'b0;
        cfg       = '0;
        res_ready = 1'b0;
        case_name = '0;
        exp_count = 0;
        repeat (4) @(negedge clk);  // Four reset cycles
        rst = 1'b1;
        for (int i = 0; i < NCASE; i++) begin
            run_case(CASES[i]);
        end
        repeat (4) @(negedge clk);
        total = chk_errors + timeouts + conv1d_top_inst.conv1d_props_inst.fail_count;
        $display("errors: checker %0d, timeouts %0d, assertions %0d", chk_errors, timeouts,
                 conv1d_top_inst.conv1d_props_inst.fail_count);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/conv_data_pkg.sv
hw/conv_ctrl_pkg.sv
hw/ifmap_buffer.sv
hw/weight_buffer.sv
hw/mac_unit.sv
hw/conv_ctrl.sv
hw/conv1d_top.sv
bench/conv1d_props.sv
bench/conv1d_checker.sv
bench/conv1d_tb.sv

/* run.sh */
#!/bin/sh
# Build the convolution testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module conv1d_tb -o conv1d_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# Keep going after an assertion error so the testbench reaches its report
out=$(./obj_dir/conv1d_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
